// ==== include/msg_fifo_consts.svh ====
`ifndef MSG_FIFO_CONSTS_SVH
`define MSG_FIFO_CONSTS_SVH

// 512 words of frame memory
`define MSG_FIFO_DEPTH_LOG2 9

// payload bytes after the length slot, per fragment
`define MSG_FIFO_FRAG_PAYLOAD 252

// header bytes up to and including the length slot
`define MSG_FIFO_HDR_BYTES 3

`endif

// ==== logic/msg_fifo_pkg.sv ====
`default_nettype none

`include "msg_fifo_consts.svh"

package msg_fifo_pkg;

	// input beat, fill_len only looked at on the first beat of a frame
	typedef struct packed {
		logic [7:0] data;
		logic       last;
		logic       fill_len;
	} in_beat_t;

	// eof set marks the word after a frame or fragment
	typedef struct packed {
		logic       eof;
		logic [7:0] data;
	} fifo_word_t;

	typedef struct packed {
		logic                            en;
		logic [`MSG_FIFO_DEPTH_LOG2-1:0] addr;
		fifo_word_t                      word;
	} ram_wr_t;

endpackage

`default_nettype wire

// ==== logic/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msg_fifo_consts.svh"

module frame_ram (
	input  wire logic                            clk,
	input  wire msg_fifo_pkg::ram_wr_t           wr,
	input  wire logic [`MSG_FIFO_DEPTH_LOG2-1:0] rd_addr,
	output msg_fifo_pkg::fifo_word_t             rd_word
);
	import msg_fifo_pkg::*;

	localparam int WORDS = 1 << `MSG_FIFO_DEPTH_LOG2;

	fifo_word_t mem [0:WORDS-1];

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.word;
		end
	end

	// reader sees the word at its tail in the same cycle
	assign rd_word = mem[rd_addr];

endmodule

`default_nettype wire

// ==== logic/frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msg_fifo_consts.svh"

module frame_writer (
	input  wire logic                            clk,
	input  wire logic                            rst,
	input  wire logic                            in_valid,
	output logic                                 in_ready,
	input  wire msg_fifo_pkg::in_beat_t          in_beat,
	input  wire logic [`MSG_FIFO_DEPTH_LOG2-1:0] tail,
	output msg_fifo_pkg::ram_wr_t                wr,
	output logic [`MSG_FIFO_DEPTH_LOG2-1:0]      head,
	output logic                                 frame_done,
	output logic                                 overflow
);
	localparam int AW = `MSG_FIFO_DEPTH_LOG2;
	localparam logic [8:0] HDR_BYTES = `MSG_FIFO_HDR_BYTES;
	// words in a full fragment, the next beat starts a new one
	localparam logic [8:0] SPLIT_CNT = `MSG_FIFO_HDR_BYTES + `MSG_FIFO_FRAG_PAYLOAD;

	typedef enum logic [3:0] {
		S_IDLE,
		S_REC,
		S_DROP,
		S_EOF,
		S_LEN,
		S_FMARK,
		S_FLEN,
		S_FHDR0,
		S_FHDR1,
		S_FSAVE
	} state_t;

	state_t state, state_nxt;

	logic [AW-1:0] head_work;
	logic [AW-1:0] start;
	logic [8:0]    byte_cnt;
	logic [8:0]    len_full;
	logic [7:0]    hdr0;
	logic [7:0]    hdr1;
	logic [7:0]    save_byte;
	logic          save_last;
	logic          fill;

	logic          accept;
	logic          full1;
	logic          full2;
	logic [1:0]    adv;
	logic [1:0]    cnt_add;
	logic          commit;
	logic          drop;
	logic          split;

	assign accept = in_valid && in_ready;
	assign full1 = (head_work + 1'b1) == tail;
	// two words needed when the new length slot is skipped
	assign full2 = full1 || ((head_work + 2'd2) == tail);
	assign len_full = byte_cnt - HDR_BYTES;

	always_comb begin
		state_nxt = state;
		wr = '0;
		wr.addr = head_work;
		wr.word.data = in_beat.data;
		adv = 2'd0;
		cnt_add = 2'd0;
		commit = 1'b0;
		drop = 1'b0;
		split = 1'b0;
		frame_done = 1'b0;

		case (state)
			S_IDLE, S_REC: begin
				if (accept) begin
					if (state == S_REC && fill && byte_cnt == SPLIT_CNT) begin
						split = 1'b1;
						state_nxt = S_FMARK;
					end else if (full1) begin
						drop = 1'b1;
						state_nxt = in_beat.last ? S_IDLE : S_DROP;
					end else begin
						wr.en = 1'b1;
						adv = 2'd1;
						cnt_add = 2'd1;
						state_nxt = in_beat.last ? S_EOF : S_REC;
					end
				end
			end
			S_DROP: begin
				if (accept && in_beat.last) begin
					state_nxt = S_IDLE;
				end
			end
			S_EOF: begin
				wr.word = '{eof: 1'b1, data: 8'h00};
				if (full1) begin
					drop = 1'b1;
					state_nxt = S_IDLE;
				end else begin
					wr.en = 1'b1;
					adv = 2'd1;
					if (fill && byte_cnt >= HDR_BYTES) begin
						state_nxt = S_LEN;
					end else begin
						commit = 1'b1;
						frame_done = 1'b1;
						state_nxt = S_IDLE;
					end
				end
			end
			S_LEN, S_FLEN: begin
				wr.en = 1'b1;
				wr.addr = start + 2'd2;
				wr.word.data = len_full[7:0];
				commit = 1'b1;
				frame_done = 1'b1;
				state_nxt = (state == S_LEN) ? S_IDLE : S_FHDR0;
			end
			S_FMARK: begin
				wr.word = '{eof: 1'b1, data: 8'h00};
				if (full1) begin
					drop = 1'b1;
					state_nxt = save_last ? S_IDLE : S_DROP;
				end else begin
					wr.en = 1'b1;
					adv = 2'd1;
					state_nxt = S_FLEN;
				end
			end
			S_FHDR0: begin
				wr.word.data = hdr0;
				if (full1) begin
					drop = 1'b1;
					state_nxt = save_last ? S_IDLE : S_DROP;
				end else begin
					wr.en = 1'b1;
					adv = 2'd1;
					cnt_add = 2'd1;
					state_nxt = S_FHDR1;
				end
			end
			S_FHDR1: begin
				wr.word.data = hdr1;
				if (full2) begin
					drop = 1'b1;
					state_nxt = save_last ? S_IDLE : S_DROP;
				end else begin
					// step over the length slot of the new fragment
					wr.en = 1'b1;
					adv = 2'd2;
					cnt_add = 2'd2;
					state_nxt = S_FSAVE;
				end
			end
			S_FSAVE: begin
				wr.word.data = save_byte;
				if (full1) begin
					drop = 1'b1;
					state_nxt = save_last ? S_IDLE : S_DROP;
				end else begin
					wr.en = 1'b1;
					adv = 2'd1;
					cnt_add = 2'd1;
					state_nxt = save_last ? S_EOF : S_REC;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			in_ready <= 1'b0;
			overflow <= 1'b0;
			head <= '0;
			head_work <= '0;
			byte_cnt <= '0;
			fill <= 1'b0;
		end else begin
			state <= state_nxt;
			in_ready <= (state_nxt == S_IDLE) || (state_nxt == S_REC) || (state_nxt == S_DROP);
			overflow <= drop;
			if (drop) begin
				// back to the last closed fragment
				head_work <= head;
				byte_cnt <= '0;
			end else begin
				head_work <= head_work + adv;
				byte_cnt <= commit ? 9'd0 : byte_cnt + cnt_add;
			end
			if (commit) begin
				head <= head_work + adv;
			end
			if (state == S_IDLE && accept) begin
				fill <= in_beat.fill_len;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE || state == S_FLEN) begin
			start <= head_work;
		end
		// keep the first two header bytes for later fragments
		if (wr.en && (state == S_IDLE || state == S_REC)) begin
			if (byte_cnt == 9'd0) begin
				hdr0 <= in_beat.data;
			end
			if (byte_cnt == 9'd1) begin
				hdr1 <= in_beat.data;
			end
		end
		if (split) begin
			save_byte <= in_beat.data;
			save_last <= in_beat.last;
		end
	end

endmodule

`default_nettype wire

// ==== logic/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msg_fifo_consts.svh"

module frame_reader (
	input  wire logic                            clk,
	input  wire logic                            rst,
	input  wire msg_fifo_pkg::fifo_word_t        rd_word,
	output logic [`MSG_FIFO_DEPTH_LOG2-1:0]      tail,
	input  wire logic                            frame_done,
	output logic                                 out_valid,
	input  wire logic                            out_ready,
	output logic [7:0]                           out_data
);
	localparam int AW = `MSG_FIFO_DEPTH_LOG2;

	logic [AW-1:0] frame_cnt;
	logic          have_frame;
	logic          skip;
	logic          take;

	// nothing leaves until a whole frame is in memory
	assign have_frame = frame_cnt != '0;

	// marker words are dropped here, never shown
	assign skip = have_frame && rd_word.eof;

	assign out_valid = have_frame && !rd_word.eof;
	assign out_data = rd_word.data;
	assign take = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			frame_cnt <= '0;
		end else begin
			if (take || skip) begin
				tail <= tail + 1'b1;
			end
			case ({frame_done, skip})
				2'b10: frame_cnt <= frame_cnt + 1'b1;
				2'b01: frame_cnt <= frame_cnt - 1'b1;
				default: frame_cnt <= frame_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/message_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msg_fifo_consts.svh"

module message_fifo (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   in_valid,
	output logic                        in_ready,
	input  wire msg_fifo_pkg::in_beat_t in_beat,
	output logic                        overflow,
	output logic                        out_valid,
	input  wire logic                   out_ready,
	output logic [7:0]                  out_data
);
	import msg_fifo_pkg::*;

	ram_wr_t                         wr;
	fifo_word_t                      rd_word;
	logic [`MSG_FIFO_DEPTH_LOG2-1:0] head;
	logic [`MSG_FIFO_DEPTH_LOG2-1:0] tail;
	logic                            frame_done;

	frame_writer u_writer (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_beat    (in_beat),
		.tail       (tail),
		.wr         (wr),
		.head       (head),
		.frame_done (frame_done),
		.overflow   (overflow)
	);

	frame_ram u_ram (
		.clk     (clk),
		.wr      (wr),
		.rd_addr (tail),
		.rd_word (rd_word)
	);

	frame_reader u_reader (
		.clk        (clk),
		.rst        (rst),
		.rd_word    (rd_word),
		.tail       (tail),
		.frame_done (frame_done),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

// ==== dv/message_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msg_fifo_consts.svh"

module message_fifo_tb;
	import msg_fifo_pkg::*;

	localparam int DEPTH = 1 << `MSG_FIFO_DEPTH_LOG2;
	localparam int HDR = `MSG_FIFO_HDR_BYTES;
	localparam int FRAG = `MSG_FIFO_FRAG_PAYLOAD;
	localparam int T1_FRAMES = 60;
	localparam int T2_FRAMES = 20;
	localparam int T3_FRAMES = 6;
	localparam int MAX_BYTES = T1_FRAMES * 40 + T2_FRAMES * 200 + T3_FRAMES * 500 + 2 * DEPTH;
	localparam int WATCH_CYCLES = MAX_BYTES * 4 + 2000;

	logic       clk;
	logic       rst;
	logic       in_valid;
	logic       in_ready;
	in_beat_t   in_beat;
	logic       overflow;
	logic       out_valid;
	logic       out_ready;
	logic [7:0] out_data;

	logic [7:0]  frame_buf [0:DEPTH-1];
	logic [7:0]  exp_q [$];
	logic [7:0]  exp_byte;
	int unsigned seed;
	int unsigned rdy_state;
	int          rdy_mode;
	int          err_cnt;
	int          ovf_cnt;
	int          stall_cnt;
	int          err_start;
	int          ovf_start;
	int          tests_run;
	int          tests_failed;

	message_fifo DUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_beat   (in_beat),
		.overflow  (overflow),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int unsigned lcg_step(input int unsigned s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned rand_below(input int unsigned m);
		seed = lcg_step(seed);
		return (seed >> 8) % m;
	endfunction

	// memory words a frame takes, markers included
	function automatic int frame_words(input int n, input logic fl);
		int left;
		int piece;
		int w;
		if (!fl || n < HDR) begin
			return n + 1;
		end
		left = n - HDR;
		w = 0;
		do begin
			piece = (left > FRAG) ? FRAG : left;
			w += HDR + piece + 1;
			left -= piece;
		end while (left > 0);
		return w;
	endfunction

	// reference model: bytes the sink should see for frame_buf
	function automatic void queue_expected(input int n, input logic fl);
		int left;
		int off;
		int piece;
		int k;
		if (!fl || n < HDR) begin
			for (k = 0; k < n; k++) begin
				exp_q.push_back(frame_buf[k]);
			end
			return;
		end
		left = n - HDR;
		off = HDR;
		do begin
			piece = (left > FRAG) ? FRAG : left;
			exp_q.push_back(frame_buf[0]);
			exp_q.push_back(frame_buf[1]);
			exp_q.push_back(8'(piece));
			for (k = 0; k < piece; k++) begin
				exp_q.push_back(frame_buf[off + k]);
			end
			off += piece;
			left -= piece;
		end while (left > 0);
	endfunction

	function automatic void fill_buffer(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			frame_buf[k] = 8'(rand_below(256));
		end
	endfunction

	task automatic idle_cycles(input int k);
		repeat (k) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// holds the beat until a clock edge with in_ready high
	task automatic send_beat(input logic [7:0] d, input logic last, input logic fl);
		logic ok;
		in_valid = 1'b1;
		in_beat = '{data: d, last: last, fill_len: fl};
		do begin
			@(negedge clk);
			ok = in_ready;
			if (!ok) begin
				stall_cnt++;
			end
			@(posedge clk);
			#2;
		end while (!ok);
		in_valid = 1'b0;
	endtask

	task automatic send_frame(input int n, input logic fl, input bit gaps);
		int k;
		logic beat_fl;
		for (k = 0; k < n; k++) begin
			if (gaps && rand_below(4) == 0) begin
				idle_cycles(1 + rand_below(3));
			end
			// later beats carry junk in fill_len
			beat_fl = (k == 0) ? fl : 1'(rand_below(2));
			send_beat(frame_buf[k], k == n - 1, beat_fl);
		end
	endtask

	// conservative bound, each queued byte may own a marker
	task automatic wait_room(input int words);
		while (2 * exp_q.size() + 1 + words > DEPTH - 1) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		idle_cycles(4);
	endtask

	task automatic start_test();
		err_start = err_cnt;
		ovf_start = ovf_cnt;
	endtask

	task automatic end_test(input int num, input string name, input int ovf_exp);
		int errs;
		if (ovf_cnt - ovf_start != ovf_exp) begin
			$display("overflow pulsed %0d times in test %0d, expected %0d",
				ovf_cnt - ovf_start, num, ovf_exp);
			err_cnt++;
		end
		errs = err_cnt - err_start;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: fail with %0d errors", num, name, errs);
			tests_failed++;
		end
	endtask

	// sink side, sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (!rst) begin
			if (overflow) begin
				ovf_cnt++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("unexpected output byte %h with nothing pending", out_data);
					err_cnt++;
				end else begin
					exp_byte = exp_q.pop_front();
					if (out_data !== exp_byte) begin
						$display("ERR out_data got %h exp %h", out_data, exp_byte);
						err_cnt++;
					end
				end
			end
		end
	end

	// 0 random, 1 always ready, else stalled
	always @(posedge clk) begin
		#2;
		if (rdy_mode == 0) begin
			rdy_state = lcg_step(rdy_state);
			out_ready = rdy_state[20];
		end else begin
			out_ready = (rdy_mode == 1);
		end
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("timeout: run still going after %0d cycles", WATCH_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int f;
		int n;
		int k;
		int occ;
		int s0;
		logic fl;
		bit dropped;
		seed = 32'd84;
		rdy_state = 32'd84;
		rdy_mode = 2;
		err_cnt = 0;
		ovf_cnt = 0;
		stall_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		start_test();
		rdy_mode = 0;
		for (f = 0; f < T1_FRAMES; f++) begin
			n = 1 + rand_below(40);
			fill_buffer(n);
			wait_room(frame_words(n, 1'b0));
			queue_expected(n, 1'b0);
			send_frame(n, 1'b0, 1'b1);
		end
		wait_drain();
		end_test(1, "plain frames", 0);

		start_test();
		for (f = 0; f < T2_FRAMES; f++) begin
			n = 3 + rand_below(198);
			fl = (rand_below(4) != 0);
			fill_buffer(n);
			wait_room(frame_words(n, fl));
			queue_expected(n, fl);
			send_frame(n, fl, 1'b1);
		end
		wait_drain();
		end_test(2, "length fill", 0);

		start_test();
		rdy_mode = 1;
		for (f = 0; f < T3_FRAMES; f++) begin
			n = 300 + rand_below(201);
			fill_buffer(n);
			wait_room(frame_words(n, 1'b1));
			queue_expected(n, 1'b1);
			s0 = stall_cnt;
			send_frame(n, 1'b1, 1'b0);
			if (stall_cnt - s0 < 5) begin
				$display("in_ready did not drop for the fragment split of frame %0d", f);
				err_cnt++;
			end
		end
		wait_drain();
		end_test(3, "fragmentation", 0);

		// tail stays put, so fullness follows the committed words
		start_test();
		rdy_mode = 2;
		idle_cycles(2);
		occ = 0;
		dropped = 1'b0;
		while (!dropped) begin
			n = 20 + rand_below(21);
			fill_buffer(n);
			if (occ + n + 1 > DEPTH - 1) begin
				dropped = 1'b1;
			end else begin
				queue_expected(n, 1'b0);
				occ += n + 1;
			end
			send_frame(n, 1'b0, 1'b0);
		end
		idle_cycles(4);
		rdy_mode = 1;
		wait_drain();
		end_test(4, "overflow drop", 1);

		start_test();
		rdy_mode = 2;
		for (k = 0; k < 30; k++) begin
			@(negedge clk);
			check_bit("out_valid", out_valid, 1'b0);
		end
		@(posedge clk);
		#2;
		// one whole frame and a partial one, both lost to the reset
		n = 12;
		fill_buffer(n);
		send_frame(n, 1'b0, 1'b0);
		for (k = 0; k < 5; k++) begin
			send_beat(8'(rand_below(256)), 1'b0, 1'b0);
		end
		rst = 1'b1;
		exp_q.delete();
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		check_bit("in_ready", in_ready, 1'b0);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("overflow", overflow, 1'b0);
		@(posedge clk);
		#2;
		rdy_mode = 1;
		n = 1 + rand_below(40);
		fill_buffer(n);
		queue_expected(n, 1'b0);
		send_frame(n, 1'b0, 1'b0);
		wait_drain();
		end_test(5, "back-pressure and reset", 0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/msg_fifo_pkg.sv
logic/frame_ram.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/message_fifo.sv
dv/message_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module message_fifo_tb \
	-o message_fifo_sim \
	&& ./obj_dir/message_fifo_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
